// ==== design/periph_defines.svh ====
/*
 * Peripheral subsystem address map, register offsets and reset values
 */
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// Bus geometry
`define PERIPH_ADDR_W 12
`define PERIPH_DATA_W 32

// Slot map, address bits 11 to 8
`define SLOT_IRQ  4'd0
`define SLOT_UART 4'd1

// Read pattern of slots with no peripheral
`define ERR_RDATA 32'hdeadbeef

`define UART_DIV_RESET 16'd8

// UART word offsets
`define UART_REG_DATA   3'd0
`define UART_REG_STATUS 3'd1
`define UART_REG_DIV    3'd2
`define UART_REG_IE     3'd3

// Interrupt controller word offsets
`define IRQ_REG_PENDING 3'd0
`define IRQ_REG_EN0     3'd1
`define IRQ_REG_EN1     3'd2

`define NUM_IRQ_SRC 2
`define NUM_IRQ_TGT 2

`endif

// ==== design/periph_pkg.sv ====
/*
 * Shared types of the peripheral subsystem
 */
`include "periph_defines.svh"

package periph_pkg;

    typedef logic [`PERIPH_ADDR_W-1:0] addr_t;
    typedef logic [`PERIPH_DATA_W-1:0] data_t;
    typedef logic [3:0]                slot_t;
    typedef logic [2:0]                regoff_t;
    typedef logic [7:0]                byte_t;
    // Clocks per serial bit
    typedef logic [15:0]               div_t;
    typedef logic [`NUM_IRQ_SRC-1:0]   irq_src_t;
    typedef logic [`NUM_IRQ_TGT-1:0]   irq_tgt_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

// ==== design/periph_bus_decode.sv ====
/*
 * Bus decoder: slot selects, read data mux and registered acknowledge
 */
`timescale 1ns/1ps
`include "periph_defines.svh"

module periph_bus_decode
    import periph_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    bus_req_i,
    input  logic    bus_we_i,
    input  addr_t   bus_addr_i,
    input  data_t   bus_wdata_i,
    input  data_t   irq_rdata_i,
    input  data_t   uart_rdata_i,
    output logic    bus_ack_o,
    output data_t   bus_rdata_o,
    output logic    bus_err_o,
    output logic    irq_sel_o,
    output logic    uart_sel_o,
    output logic    we_o,
    output regoff_t regoff_o,
    output data_t   wdata_o
);

    slot_t slot;
    logic  absent;
    data_t rdata_mux;

    assign slot     = bus_addr_i[`PERIPH_ADDR_W-1:8];
    assign regoff_o = bus_addr_i[4:2];
    assign we_o     = bus_we_i;
    assign wdata_o  = bus_wdata_i;

    assign absent     = (slot != `SLOT_IRQ) && (slot != `SLOT_UART);
    assign irq_sel_o  = bus_req_i && (slot == `SLOT_IRQ);
    assign uart_sel_o = bus_req_i && (slot == `SLOT_UART);

    always_comb begin
        if (bus_we_i) begin
            rdata_mux = '0;
        end else if (absent) begin
            rdata_mux = `ERR_RDATA;
        end else if (slot == `SLOT_UART) begin
            rdata_mux = uart_rdata_i;
        end else begin
            rdata_mux = irq_rdata_i;
        end
    end

    // Response goes out one cycle after the request
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus_ack_o   <= 1'b0;
            bus_err_o   <= 1'b0;
            bus_rdata_o <= '0;
        end else begin
            bus_ack_o <= bus_req_i;
            bus_err_o <= bus_req_i && absent;
            if (bus_req_i) begin
                bus_rdata_o <= rdata_mux;
            end
        end
    end

endmodule

// ==== design/uart_tx.sv ====
/*
 * UART transmitter, one 8N1 frame per start pulse
 */
`timescale 1ns/1ps

module uart_tx
    import periph_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  start_i,
    input  byte_t data_i,
    input  div_t  div_i,
    output logic  tx_o,
    output logic  busy_o
);

    tx_state_e  state_q;
    div_t       cnt_q;
    div_t       div_q;
    byte_t      shift_q;
    logic [2:0] bit_q;
    logic       bit_end;

    assign bit_end = (cnt_q == div_q - 1'b1);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= TX_IDLE;
            cnt_q   <= '0;
            div_q   <= '0;
            shift_q <= '0;
            bit_q   <= '0;
        end else begin
            if (state_q != TX_IDLE) begin
                cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
            end
            case (state_q)
                TX_IDLE: begin
                    if (start_i) begin
                        state_q <= TX_START;
                        cnt_q   <= '0;
                        div_q   <= div_i;
                        shift_q <= data_i;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state_q <= TX_DATA;
                        bit_q   <= '0;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        shift_q <= shift_q >> 1;
                        bit_q   <= bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_q <= TX_STOP;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state_q <= TX_IDLE;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    always_comb begin
        case (state_q)
            TX_START: tx_o = 1'b0;
            TX_DATA:  tx_o = shift_q[0];
            default:  tx_o = 1'b1;
        endcase
    end

    assign busy_o = (state_q != TX_IDLE);

endmodule

// ==== design/uart_rx.sv ====
/*
 * UART receiver, 8N1 with mid-bit sampling and framing check
 */
`timescale 1ns/1ps

module uart_rx
    import periph_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  rx_i,
    input  div_t  div_i,
    output byte_t data_o,
    output logic  valid_o
);

    logic       rx_s1;
    logic       rx_s2;
    logic       rx_prev;
    rx_state_e  state_q;
    div_t       cnt_q;
    div_t       div_q;
    div_t       half;
    byte_t      shift_q;
    logic [2:0] bit_q;
    logic       bit_end;

    // ----------------------------------------
    // Input synchronizer
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_s1   <= 1'b1;
            rx_s2   <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_s1   <= rx_i;
            rx_s2   <= rx_s1;
            rx_prev <= rx_s2;
        end
    end

    // ----------------------------------------
    // Frame FSM
    // ----------------------------------------
    assign half    = div_q >> 1;
    assign bit_end = (cnt_q == div_q - 1'b1);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RX_IDLE;
            cnt_q   <= '0;
            div_q   <= '0;
            shift_q <= '0;
            bit_q   <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    // Count starts at 1 to absorb the synchronizer delay
                    if (rx_prev && !rx_s2) begin
                        state_q <= RX_START;
                        cnt_q   <= 16'd1;
                        div_q   <= div_i;
                    end
                end
                RX_START: begin
                    if (cnt_q >= half) begin
                        cnt_q   <= '0;
                        bit_q   <= '0;
                        state_q <= rx_s2 ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cnt_q   <= '0;
                        shift_q <= {rx_s2, shift_q[7:1]};
                        bit_q   <= bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        cnt_q   <= '0;
                        state_q <= RX_IDLE;
                        valid_o <= rx_s2;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    assign data_o = shift_q;

endmodule

// ==== design/uart_regs.sv ====
/*
 * UART register block: data, status, divisor and interrupt enable,
 * wrapped around the serializer and deserializer
 */
`timescale 1ns/1ps
`include "periph_defines.svh"

module uart_regs
    import periph_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     sel_i,
    input  logic     we_i,
    input  regoff_t  regoff_i,
    input  data_t    wdata_i,
    input  logic     rx_i,
    output data_t    rdata_o,
    output logic     tx_o,
    output irq_src_t irq_src_o
);

    div_t  div_q;
    logic  ie_q;
    byte_t rx_data_q;
    logic  rx_valid_q;
    logic  rx_overrun_q;
    logic  tx_busy;
    logic  tx_busy_d;
    logic  tx_start;
    byte_t rx_byte;
    logic  rx_pulse;
    logic  wr;
    logic  pop;

    assign wr       = sel_i && we_i;
    assign pop      = sel_i && !we_i && (regoff_i == `UART_REG_DATA);
    assign tx_start = wr && (regoff_i == `UART_REG_DATA) && !tx_busy;

    uart_tx u_tx (
        .clk_i   ( clk_i         ),
        .rst_n_i ( rst_n_i       ),
        .start_i ( tx_start      ),
        .data_i  ( wdata_i[7:0]  ),
        .div_i   ( div_q         ),
        .tx_o    ( tx_o          ),
        .busy_o  ( tx_busy       )
    );

    uart_rx u_rx (
        .clk_i   ( clk_i    ),
        .rst_n_i ( rst_n_i  ),
        .rx_i    ( rx_i     ),
        .div_i   ( div_q    ),
        .data_o  ( rx_byte  ),
        .valid_o ( rx_pulse )
    );

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_q        <= `UART_DIV_RESET;
            ie_q         <= 1'b0;
            rx_data_q    <= '0;
            rx_valid_q   <= 1'b0;
            rx_overrun_q <= 1'b0;
            tx_busy_d    <= 1'b0;
        end else begin
            tx_busy_d <= tx_busy;
            if (wr && regoff_i == `UART_REG_DIV) begin
                div_q <= wdata_i[15:0];
            end
            if (wr && regoff_i == `UART_REG_IE) begin
                ie_q <= wdata_i[0];
            end
            if (pop) begin
                rx_valid_q   <= 1'b0;
                rx_overrun_q <= 1'b0;
            end
            // A new character wins over a pop on the same edge
            if (rx_pulse) begin
                rx_data_q    <= rx_byte;
                rx_valid_q   <= 1'b1;
                rx_overrun_q <= rx_valid_q && !pop;
            end
        end
    end

    always_comb begin
        case (regoff_i)
            `UART_REG_DATA:   rdata_o = data_t'(rx_data_q);
            `UART_REG_STATUS: rdata_o = data_t'({rx_overrun_q, rx_valid_q, tx_busy});
            `UART_REG_DIV:    rdata_o = data_t'(div_q);
            `UART_REG_IE:     rdata_o = data_t'(ie_q);
            default:          rdata_o = '0;
        endcase
    end

    // Source 1 fires when the transmitter goes idle
    assign irq_src_o[0] = rx_valid_q && ie_q;
    assign irq_src_o[1] = tx_busy_d && !tx_busy;

endmodule

// ==== design/irq_ctrl.sv ====
/*
 * Interrupt controller: edge-latched pending bits, per-target enables
 */
`timescale 1ns/1ps
`include "periph_defines.svh"

module irq_ctrl
    import periph_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     sel_i,
    input  logic     we_i,
    input  regoff_t  regoff_i,
    input  data_t    wdata_i,
    input  irq_src_t irq_src_i,
    output data_t    rdata_o,
    output irq_tgt_t irq_o
);

    irq_src_t src_d;
    irq_src_t rise;
    irq_src_t clr;
    irq_src_t pending_q;
    irq_src_t en_q [`NUM_IRQ_TGT];
    logic     wr;

    assign wr   = sel_i && we_i;
    assign rise = irq_src_i & ~src_d;
    assign clr  = (wr && regoff_i == `IRQ_REG_PENDING) ?
                  wdata_i[`NUM_IRQ_SRC-1:0] : '0;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            src_d     <= '0;
            pending_q <= '0;
            for (int t = 0; t < `NUM_IRQ_TGT; t++) begin
                en_q[t] <= '0;
            end
        end else begin
            src_d <= irq_src_i;
            // Set beats clear
            pending_q <= (pending_q & ~clr) | rise;
            for (int t = 0; t < `NUM_IRQ_TGT; t++) begin
                if (wr && regoff_i == regoff_t'(`IRQ_REG_EN0 + t)) begin
                    en_q[t] <= wdata_i[`NUM_IRQ_SRC-1:0];
                end
            end
        end
    end

    always_comb begin
        case (regoff_i)
            `IRQ_REG_PENDING: rdata_o = data_t'(pending_q);
            `IRQ_REG_EN0:     rdata_o = data_t'(en_q[0]);
            `IRQ_REG_EN1:     rdata_o = data_t'(en_q[1]);
            default:          rdata_o = '0;
        endcase
    end

    for (genvar t = 0; t < `NUM_IRQ_TGT; t++) begin : gen_tgt
        assign irq_o[t] = |(pending_q & en_q[t]);
    end

endmodule

// ==== design/periph_top.sv ====
/*
 * Peripheral subsystem top: bus decoder, UART and interrupt controller
 */
`timescale 1ns/1ps

module periph_top
    import periph_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     bus_req_i,
    input  logic     bus_we_i,
    input  addr_t    bus_addr_i,
    input  data_t    bus_wdata_i,
    input  logic     rx_i,
    output logic     bus_ack_o,
    output data_t    bus_rdata_o,
    output logic     bus_err_o,
    output logic     tx_o,
    output irq_tgt_t irq_o
);

    logic     irq_sel;
    logic     uart_sel;
    logic     we;
    regoff_t  regoff;
    data_t    wdata;
    data_t    irq_rdata;
    data_t    uart_rdata;
    irq_src_t irq_src;

    periph_bus_decode u_decode (
        .clk_i        ( clk_i       ),
        .rst_n_i      ( rst_n_i     ),
        .bus_req_i    ( bus_req_i   ),
        .bus_we_i     ( bus_we_i    ),
        .bus_addr_i   ( bus_addr_i  ),
        .bus_wdata_i  ( bus_wdata_i ),
        .irq_rdata_i  ( irq_rdata   ),
        .uart_rdata_i ( uart_rdata  ),
        .bus_ack_o    ( bus_ack_o   ),
        .bus_rdata_o  ( bus_rdata_o ),
        .bus_err_o    ( bus_err_o   ),
        .irq_sel_o    ( irq_sel     ),
        .uart_sel_o   ( uart_sel    ),
        .we_o         ( we          ),
        .regoff_o     ( regoff      ),
        .wdata_o      ( wdata       )
    );

    uart_regs u_uart (
        .clk_i     ( clk_i      ),
        .rst_n_i   ( rst_n_i    ),
        .sel_i     ( uart_sel   ),
        .we_i      ( we         ),
        .regoff_i  ( regoff     ),
        .wdata_i   ( wdata      ),
        .rx_i      ( rx_i       ),
        .rdata_o   ( uart_rdata ),
        .tx_o      ( tx_o       ),
        .irq_src_o ( irq_src    )
    );

    irq_ctrl u_irq (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .sel_i     ( irq_sel   ),
        .we_i      ( we        ),
        .regoff_i  ( regoff    ),
        .wdata_i   ( wdata     ),
        .irq_src_i ( irq_src   ),
        .rdata_o   ( irq_rdata ),
        .irq_o     ( irq_o     )
    );

endmodule

// ==== dv/tb_periph.sv ====
/*
 * Testbench for the peripheral subsystem: bus decode, UART and interrupts
 */
`timescale 1ns/1ps
`include "periph_defines.svh"

module tb_periph
    import periph_pkg::*;
();

    localparam int          CLK_PERIOD = 100;
    localparam int          TB_DIV     = 16;
    localparam logic [31:0] SEED       = 32'h1e83605a;
    localparam int          TIMEOUT_NS = (4000 * TB_DIV + 1000) * CLK_PERIOD;

    // Status word bits
    localparam data_t STAT_TX_BUSY  = 32'h1;
    localparam data_t STAT_RX_VALID = 32'h2;
    localparam data_t STAT_RX_OVR   = 32'h4;

    logic     clk;
    logic     rst_n;
    logic     bus_req;
    logic     bus_we;
    addr_t    bus_addr;
    data_t    bus_wdata;
    logic     rx;
    logic     bus_ack;
    data_t    bus_rdata;
    logic     bus_err;
    logic     tx;
    irq_tgt_t irq;
    logic     req_q = 1'b0;
    logic     err_q = 1'b0;

    periph_top uut (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .bus_req_i   ( bus_req   ),
        .bus_we_i    ( bus_we    ),
        .bus_addr_i  ( bus_addr  ),
        .bus_wdata_i ( bus_wdata ),
        .rx_i        ( rx        ),
        .bus_ack_o   ( bus_ack   ),
        .bus_rdata_o ( bus_rdata ),
        .bus_err_o   ( bus_err   ),
        .tx_o        ( tx        ),
        .irq_o       ( irq       )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic mismatch(input string name, input data_t exp, input data_t act);
        fail_run($sformatf("MISMATCH at %0d ns: %s expected %h, got %h",
                           $time, name, exp, act));
    endtask

    task automatic check_eq(input string name, input data_t exp, input data_t act);
        assert (act == exp) else mismatch(name, exp, act);
    endtask

    function automatic logic slot_absent(input slot_t slot);
        return (slot != `SLOT_IRQ) && (slot != `SLOT_UART);
    endfunction

    function automatic addr_t reg_addr(input slot_t slot, input regoff_t off);
        return {slot, 3'b000, off, 2'b00};
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Called on a falling edge, so requests can follow back to back
    task automatic bus_access(input logic we, input addr_t addr, input data_t wdata,
                              input logic exp_err, output data_t rdata);
        bus_req   = 1'b1;
        bus_we    = we;
        bus_addr  = addr;
        bus_wdata = wdata;
        @(negedge clk);
        bus_req = 1'b0;
        check_eq("bus_ack_o", 32'h1, data_t'(bus_ack));
        check_eq("bus_err_o", data_t'(exp_err), data_t'(bus_err));
        rdata = bus_rdata;
    endtask

    task automatic reg_write(input slot_t slot, input regoff_t off, input data_t wdata);
        data_t unused;
        bus_access(1'b1, reg_addr(slot, off), wdata, slot_absent(slot), unused);
    endtask

    task automatic reg_read(input slot_t slot, input regoff_t off, output data_t rdata);
        bus_access(1'b0, reg_addr(slot, off), '0, slot_absent(slot), rdata);
    endtask

    task automatic reg_expect(input slot_t slot, input regoff_t off, input data_t exp);
        data_t rdata;
        reg_read(slot, off, rdata);
        check_eq($sformatf("bus_rdata_o[slot %0d, off %0d]", slot, off), exp, rdata);
    endtask

    // 8N1 frame on rx, LSB first
    task automatic send_frame(input byte_t data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            wait_cycles(TB_DIV);
        end
        rx = 1'b1;
    endtask

    // Entered half a clock after the start bit begins
    task automatic check_tx_frame(input byte_t data);
        wait_cycles(TB_DIV / 2);
        check_eq("tx_o start bit", 32'h0, data_t'(tx));
        for (int i = 0; i < 8; i++) begin
            wait_cycles(TB_DIV);
            check_eq($sformatf("tx_o data bit %0d", i), data_t'(data[i]), data_t'(tx));
        end
        wait_cycles(TB_DIV);
        check_eq("tx_o stop bit", 32'h1, data_t'(tx));
    endtask

    task automatic wait_rx_valid();
        data_t status;
        int    polls;
        polls = 0;
        do begin
            reg_read(`SLOT_UART, `UART_REG_STATUS, status);
            polls++;
            if (polls > 12 * TB_DIV) begin
                fail_run("Timeout waiting for rx_valid in the UART status");
            end
        end while (!status[1]);
    endtask

    task automatic wait_irq(input int idx);
        int cycles;
        cycles = 0;
        while (!irq[idx]) begin
            if (cycles > 12 * TB_DIV) begin
                fail_run($sformatf("Timeout waiting for irq_o[%0d]", idx));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // ----------------------------------------
    // Bus response and reset checks
    // ----------------------------------------
    always @(posedge clk) begin
        req_q <= bus_req;
        err_q <= bus_req && slot_absent(bus_addr[11:8]);
    end

    ack_timing: assert property (@(negedge clk) bus_ack == req_q)
        else mismatch("bus_ack_o", data_t'(req_q), data_t'(bus_ack));
    err_flag: assert property (@(negedge clk) bus_err == err_q)
        else mismatch("bus_err_o", data_t'(err_q), data_t'(bus_err));
    tx_reset: assert property (@(negedge clk) !rst_n |-> tx)
        else mismatch("tx_o", 32'h1, data_t'(tx));
    irq_reset: assert property (@(negedge clk) !rst_n |-> irq == '0)
        else mismatch("irq_o", 32'h0, data_t'(irq));

    initial begin
        #(TIMEOUT_NS);
        fail_run("Watchdog expired before the tests finished");
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        byte_t tx_byte;
        byte_t rx_byte1;
        byte_t rx_byte2;
        void'($urandom(SEED));
        rst_n     = 1'b0;
        bus_req   = 1'b0;
        bus_we    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        rx        = 1'b1;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // Absent slots and undefined offsets
        reg_expect(4'd2, 3'd0, `ERR_RDATA);
        reg_expect(4'd15, 3'd5, `ERR_RDATA);
        reg_write(4'd3, `UART_REG_DIV, 32'h1);
        reg_write(`SLOT_UART, 3'd7, 32'hffff_ffff);
        reg_expect(`SLOT_UART, 3'd6, 32'h0);
        reg_expect(`SLOT_IRQ, 3'd5, 32'h0);

        // Reset values, then read back written values
        reg_expect(`SLOT_UART, `UART_REG_DIV, data_t'(`UART_DIV_RESET));
        reg_expect(`SLOT_UART, `UART_REG_STATUS, 32'h0);
        reg_expect(`SLOT_UART, `UART_REG_IE, 32'h0);
        reg_expect(`SLOT_IRQ, `IRQ_REG_PENDING, 32'h0);
        reg_expect(`SLOT_IRQ, `IRQ_REG_EN0, 32'h0);
        reg_expect(`SLOT_IRQ, `IRQ_REG_EN1, 32'h0);
        reg_write(`SLOT_UART, `UART_REG_DIV, data_t'(TB_DIV));
        reg_expect(`SLOT_UART, `UART_REG_DIV, data_t'(TB_DIV));
        reg_write(`SLOT_UART, `UART_REG_IE, 32'h1);
        reg_expect(`SLOT_UART, `UART_REG_IE, 32'h1);
        reg_write(`SLOT_UART, `UART_REG_IE, 32'h0);
        reg_write(`SLOT_IRQ, `IRQ_REG_EN0, 32'h3);
        reg_write(`SLOT_IRQ, `IRQ_REG_EN1, 32'h2);
        reg_expect(`SLOT_IRQ, `IRQ_REG_EN0, 32'h3);
        reg_expect(`SLOT_IRQ, `IRQ_REG_EN1, 32'h2);
        reg_write(`SLOT_IRQ, `IRQ_REG_EN0, 32'h0);
        reg_write(`SLOT_IRQ, `IRQ_REG_EN1, 32'h0);

        // Transmit, with a second write while busy
        tx_byte = byte_t'($urandom);
        reg_write(`SLOT_UART, `UART_REG_DATA, data_t'(tx_byte));
        check_eq("tx_o", 32'h0, data_t'(tx));
        fork
            check_tx_frame(tx_byte);
            begin
                reg_write(`SLOT_UART, `UART_REG_DATA, data_t'(~tx_byte));
                reg_expect(`SLOT_UART, `UART_REG_STATUS, STAT_TX_BUSY);
            end
        join
        wait_cycles(TB_DIV);
        check_eq("tx_o idle", 32'h1, data_t'(tx));
        reg_expect(`SLOT_UART, `UART_REG_STATUS, 32'h0);
        reg_expect(`SLOT_IRQ, `IRQ_REG_PENDING, 32'h2);
        reg_write(`SLOT_IRQ, `IRQ_REG_PENDING, 32'h2);
        reg_expect(`SLOT_IRQ, `IRQ_REG_PENDING, 32'h0);

        // Receive, overrun, framing error
        rx_byte1 = byte_t'($urandom);
        send_frame(rx_byte1, 1'b1);
        wait_rx_valid();
        reg_expect(`SLOT_UART, `UART_REG_DATA, data_t'(rx_byte1));
        reg_expect(`SLOT_UART, `UART_REG_STATUS, 32'h0);
        rx_byte1 = byte_t'($urandom);
        // Second byte always differs from the first
        rx_byte2 = rx_byte1 ^ byte_t'($urandom_range(255, 1));
        send_frame(rx_byte1, 1'b1);
        send_frame(rx_byte2, 1'b1);
        wait_rx_valid();
        reg_expect(`SLOT_UART, `UART_REG_STATUS, STAT_RX_VALID | STAT_RX_OVR);
        reg_expect(`SLOT_UART, `UART_REG_DATA, data_t'(rx_byte2));
        reg_expect(`SLOT_UART, `UART_REG_STATUS, 32'h0);
        send_frame(byte_t'($urandom), 1'b0);
        wait_cycles(TB_DIV);
        reg_expect(`SLOT_UART, `UART_REG_STATUS, 32'h0);

        // Receive interrupt on target 0
        reg_write(`SLOT_UART, `UART_REG_IE, 32'h1);
        reg_write(`SLOT_IRQ, `IRQ_REG_EN0, 32'h1);
        rx_byte1 = byte_t'($urandom);
        send_frame(rx_byte1, 1'b1);
        wait_irq(0);
        check_eq("irq_o", 32'h1, data_t'(irq));
        reg_expect(`SLOT_IRQ, `IRQ_REG_PENDING, 32'h1);
        reg_expect(`SLOT_UART, `UART_REG_DATA, data_t'(rx_byte1));
        reg_write(`SLOT_IRQ, `IRQ_REG_PENDING, 32'h3);
        reg_expect(`SLOT_IRQ, `IRQ_REG_PENDING, 32'h0);
        check_eq("irq_o", 32'h0, data_t'(irq));

        // Transmitter idle interrupt on target 1
        reg_write(`SLOT_IRQ, `IRQ_REG_EN1, 32'h2);
        tx_byte = byte_t'($urandom);
        reg_write(`SLOT_UART, `UART_REG_DATA, data_t'(tx_byte));
        wait_irq(1);
        check_eq("irq_o", 32'h2, data_t'(irq));
        reg_expect(`SLOT_IRQ, `IRQ_REG_PENDING, 32'h2);
        reg_write(`SLOT_IRQ, `IRQ_REG_PENDING, 32'h3);
        reg_expect(`SLOT_IRQ, `IRQ_REG_PENDING, 32'h0);
        check_eq("irq_o", 32'h0, data_t'(irq));

        $display("Test passed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+design
design/periph_pkg.sv
design/periph_bus_decode.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_regs.sv
design/irq_ctrl.sv
design/periph_top.sv
dv/tb_periph.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the peripheral subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_periph -f src.f

# A $fatal in the testbench gives a failing exit status
./obj_dir/Vtb_periph
